//--- noc_route_pkg.sv
package noc_route_pkg;

    // width of the port field carried between routers
    localparam int PORT_W = 3;

    // mesh router ports, values match the switch port numbering
    typedef enum logic [PORT_W-1:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_t;

    // default mesh size
    localparam int DEF_NX = 4; // columns
    localparam int DEF_NY = 4; // rows

endpackage

//--- mesh_addr_decode.sv
module mesh_addr_decode #(
    parameter int NX = 4,
    parameter int NY = 4
) (
    input  logic [((NX > 1) ? $clog2(NX) : 1) + ((NY > 1) ? $clog2(NY) : 1)-1:0] r_addr,
    output logic [((NX > 1) ? $clog2(NX) : 1)-1:0] x,
    output logic [((NY > 1) ? $clog2(NY) : 1)-1:0] y,
    output logic in_range
);

    localparam int XW  = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW  = (NY > 1) ? $clog2(NY) : 1;
    localparam int RAW = XW + YW;

    // limits one bit wider so NX equal to 2**XW still fits
    localparam logic [XW:0] X_LIM = (XW + 1)'(NX);
    localparam logic [YW:0] Y_LIM = (YW + 1)'(NY);

    logic x_ok;
    logic y_ok;

    assign x = r_addr[XW-1:0];      // x in the low bits
    assign y = r_addr[RAW-1:XW];    // y above it

    // only matters when a dimension is not a power of two
    assign x_ok = ({1'b0, x} < X_LIM);
    assign y_ok = ({1'b0, y} < Y_LIM);

    assign in_range = x_ok & y_ok;

endmodule

//--- xy_port_select.sv
module xy_port_select #(
    parameter int NX = 4,
    parameter int NY = 4
) (
    input  logic [((NX > 1) ? $clog2(NX) : 1)-1:0] cur_x,
    input  logic [((NY > 1) ? $clog2(NY) : 1)-1:0] cur_y,
    input  logic [((NX > 1) ? $clog2(NX) : 1)-1:0] dest_x,
    input  logic [((NY > 1) ? $clog2(NY) : 1)-1:0] dest_y,
    output noc_route_pkg::port_t port
);

    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    logic [XW-1:0] dx_unused;
    logic [YW-1:0] dy_unused;

    logic x_gt;
    logic y_gt;

    assign dx_unused = dest_x ^ cur_x; // nonzero means x still to travel
    assign dy_unused = dest_y ^ cur_y;

    assign x_gt = (dest_x > cur_x);
    assign y_gt = (dest_y > cur_y);

    // dimension ordered, finish x before turning into y
    always_comb begin
        if (|dx_unused) begin
            port = x_gt ? noc_route_pkg::EAST : noc_route_pkg::WEST;
        end else if (|dy_unused) begin
            // y grows toward the south edge
            port = y_gt ? noc_route_pkg::SOUTH : noc_route_pkg::NORTH;
        end else begin
            port = noc_route_pkg::LOCAL; // arrived
        end
    end

endmodule

//--- next_router_step.sv
module next_router_step #(
    parameter int NX = 4,
    parameter int NY = 4
) (
    input  logic [((NX > 1) ? $clog2(NX) : 1)-1:0] cur_x,
    input  logic [((NY > 1) ? $clog2(NY) : 1)-1:0] cur_y,
    input  noc_route_pkg::port_t port,
    output logic [((NX > 1) ? $clog2(NX) : 1)-1:0] next_x,
    output logic [((NY > 1) ? $clog2(NY) : 1)-1:0] next_y
);

    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    // last column and row of the mesh
    localparam logic [XW-1:0] X_MAX = XW'(NX - 1);
    localparam logic [YW-1:0] Y_MAX = YW'(NY - 1);

    logic at_east;
    logic at_west;
    logic at_south;
    logic at_north;

    assign at_east  = (cur_x >= X_MAX);
    assign at_west  = (cur_x == '0);
    assign at_south = (cur_y >= Y_MAX);
    assign at_north = (cur_y == '0);

    // neighbour reached through port, saturates at the mesh border
    always_comb begin
        next_x = cur_x;
        next_y = cur_y;
        case (port)
            noc_route_pkg::EAST: begin
                if (!at_east) next_x = cur_x + 1'b1;
            end
            noc_route_pkg::WEST: begin
                if (!at_west) next_x = cur_x - 1'b1;
            end
            noc_route_pkg::SOUTH: begin
                if (!at_south) next_y = cur_y + 1'b1;
            end
            noc_route_pkg::NORTH: begin
                if (!at_north) next_y = cur_y - 1'b1;
            end
            default: begin
                next_x = cur_x; // local, stay here
                next_y = cur_y;
            end
        endcase
    end

endmodule

//--- lookahead_route_ctrl.sv
module lookahead_route_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  noc_route_pkg::port_t cur_port,
    input  noc_route_pkg::port_t lk_port,
    input  logic cur_ok,
    input  logic dest_ok,
    output noc_route_pkg::port_t destport,
    output logic out_valid,
    output noc_route_pkg::port_t out_destport,
    output noc_route_pkg::port_t out_lkdestport,
    output logic out_addr_err
);

    logic addr_ok;
    noc_route_pkg::port_t lk_port_q_d; // look-ahead value to capture

    assign addr_ok = cur_ok & dest_ok;

    // bad address goes to the local port
    assign destport = addr_ok ? cur_port : noc_route_pkg::LOCAL;
    assign lk_port_q_d = addr_ok ? lk_port : noc_route_pkg::LOCAL;

    // valid pulse, one cycle behind the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // result registers, hold between strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_destport   <= noc_route_pkg::LOCAL;
            out_lkdestport <= noc_route_pkg::LOCAL;
            out_addr_err   <= 1'b0;
        end else if (in_valid) begin
            out_destport   <= destport;
            out_lkdestport <= lk_port_q_d;    // port at the next router
            out_addr_err   <= ~addr_ok;
        end
    end

endmodule

//--- mesh_lookahead_route.sv
module mesh_lookahead_route #(
    parameter int NX = noc_route_pkg::DEF_NX,
    parameter int NY = noc_route_pkg::DEF_NY
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic [((NX > 1) ? $clog2(NX) : 1) + ((NY > 1) ? $clog2(NY) : 1)-1:0] cur_r_addr,
    input  logic [((NX > 1) ? $clog2(NX) : 1) + ((NY > 1) ? $clog2(NY) : 1)-1:0] dest_e_addr,
    output noc_route_pkg::port_t destport,
    output logic out_valid,
    output noc_route_pkg::port_t out_destport,
    output noc_route_pkg::port_t out_lkdestport,
    output logic out_addr_err
);

    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    logic [XW-1:0] cur_x;
    logic [YW-1:0] cur_y;
    logic [XW-1:0] dest_x;
    logic [YW-1:0] dest_y;
    logic [XW-1:0] next_x;
    logic [YW-1:0] next_y;
    logic cur_ok;
    logic dest_ok;

    noc_route_pkg::port_t cur_port;
    noc_route_pkg::port_t lk_port;

    // endpoint address equals router address in a plain mesh
    mesh_addr_decode #(
        .NX(NX),
        .NY(NY)
    ) cur_dec (
        .r_addr   (cur_r_addr),
        .x        (cur_x),
        .y        (cur_y),
        .in_range (cur_ok)
    );

    mesh_addr_decode #(
        .NX(NX),
        .NY(NY)
    ) dest_dec (
        .r_addr   (dest_e_addr),
        .x        (dest_x),
        .y        (dest_y),
        .in_range (dest_ok)
    );

    // port taken at this router
    xy_port_select #(
        .NX(NX),
        .NY(NY)
    ) cur_sel (
        .cur_x  (cur_x),
        .cur_y  (cur_y),
        .dest_x (dest_x),
        .dest_y (dest_y),
        .port   (cur_port)
    );

    next_router_step #(
        .NX(NX),
        .NY(NY)
    ) step0 (
        .cur_x  (cur_x),
        .cur_y  (cur_y),
        .port   (cur_port),
        .next_x (next_x),
        .next_y (next_y)
    );

    // port the next router will take
    xy_port_select #(
        .NX(NX),
        .NY(NY)
    ) lk_sel (
        .cur_x  (next_x),
        .cur_y  (next_y),
        .dest_x (dest_x),
        .dest_y (dest_y),
        .port   (lk_port)
    );

    lookahead_route_ctrl ctrl0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .cur_port       (cur_port),
        .lk_port        (lk_port),
        .cur_ok         (cur_ok),
        .dest_ok        (dest_ok),
        .destport       (destport),
        .out_valid      (out_valid),
        .out_destport   (out_destport),
        .out_lkdestport (out_lkdestport),
        .out_addr_err   (out_addr_err)
    );

endmodule

//--- tb_mesh_route.sv
module tb_mesh_route;

    localparam int NX  = 4;
    localparam int NY  = 3;
    localparam int XW  = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW  = (NY > 1) ? $clog2(NY) : 1;
    localparam int RAW = XW + YW;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic [RAW-1:0] cur_r_addr;
    logic [RAW-1:0] dest_e_addr;
    noc_route_pkg::port_t destport;
    logic out_valid;
    noc_route_pkg::port_t out_destport;
    noc_route_pkg::port_t out_lkdestport;
    logic out_addr_err;

    int mismatch_count;
    int timeout_count;

    noc_route_pkg::port_t exp_port_q[$]; // stream expectations, oldest first
    noc_route_pkg::port_t exp_lk_q[$];

    mesh_lookahead_route #(
        .NX(NX),
        .NY(NY)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .cur_r_addr     (cur_r_addr),
        .dest_e_addr    (dest_e_addr),
        .destport       (destport),
        .out_valid      (out_valid),
        .out_destport   (out_destport),
        .out_lkdestport (out_lkdestport),
        .out_addr_err   (out_addr_err)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reference XY rule, x first then y
    function automatic noc_route_pkg::port_t xy_ref(int cx, int cy, int dx, int dy);
        if (dx > cx) return noc_route_pkg::EAST;
        if (dx < cx) return noc_route_pkg::WEST;
        if (dy > cy) return noc_route_pkg::SOUTH;
        if (dy < cy) return noc_route_pkg::NORTH;
        return noc_route_pkg::LOCAL;
    endfunction

    function automatic int step_x(int cx, noc_route_pkg::port_t p);
        if (p == noc_route_pkg::EAST && cx < NX - 1) return cx + 1;
        if (p == noc_route_pkg::WEST && cx > 0) return cx - 1;
        return cx;
    endfunction

    function automatic int step_y(int cy, noc_route_pkg::port_t p);
        if (p == noc_route_pkg::SOUTH && cy < NY - 1) return cy + 1;
        if (p == noc_route_pkg::NORTH && cy > 0) return cy - 1;
        return cy;
    endfunction

    function automatic logic [RAW-1:0] pack_addr(int x, int y);
        return RAW'((y << XW) | x); // y above x
    endfunction

    task automatic check_port(input noc_route_pkg::port_t got, input noc_route_pkg::port_t exp,
                              input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %s expected %s", $time, msg, got.name(), exp.name());
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
            mismatch_count++;
        end
    endtask

    // sample on falling edges until the pulse shows up
    task automatic wait_out_valid(input string tag);
        int count;
        count = 0;
        @(negedge clk);
        while (out_valid !== 1'b1 && count < 20) begin
            @(negedge clk);
            count++;
        end
        if (out_valid !== 1'b1) begin
            $display("Timeout at %0t: no out_valid pulse for %s within 20 cycles", $time, tag);
            timeout_count++;
        end
    endtask

    // one request, checked at both pipeline stages
    task automatic route_case(input int cx, input int cy, input int dx, input int dy,
                              input string tag);
        logic ok;
        noc_route_pkg::port_t exp_port;
        noc_route_pkg::port_t exp_lk;
        ok = (cx < NX) && (cy < NY) && (dx < NX) && (dy < NY);
        exp_port = ok ? xy_ref(cx, cy, dx, dy) : noc_route_pkg::LOCAL;
        exp_lk = ok ? xy_ref(step_x(cx, exp_port), step_y(cy, exp_port), dx, dy)
                    : noc_route_pkg::LOCAL;
        @(posedge clk);
        in_valid    <= 1'b1;
        cur_r_addr  <= pack_addr(cx, cy);
        dest_e_addr <= pack_addr(dx, dy);
        @(negedge clk);
        check_port(destport, exp_port, {tag, " destport"});
        @(posedge clk);
        in_valid <= 1'b0;
        wait_out_valid(tag);
        check_port(out_destport, exp_port, {tag, " out_destport"});
        check_port(out_lkdestport, exp_lk, {tag, " out_lkdestport"});
        check_flag(out_addr_err, ~ok, {tag, " out_addr_err"});
    endtask

    task automatic reset_state_test();
        @(negedge clk);
        check_flag(out_valid, 1'b0, "reset out_valid");
        check_flag(out_addr_err, 1'b0, "reset out_addr_err");
        check_port(out_destport, noc_route_pkg::LOCAL, "reset out_destport");
        check_port(out_lkdestport, noc_route_pkg::LOCAL, "reset out_lkdestport");
    endtask

    task automatic directed_xy_test();
        route_case(1, 1, 3, 1, "xy east");
        route_case(1, 1, 0, 2, "xy west");
        route_case(1, 1, 1, 0, "xy north");
        route_case(1, 1, 1, 2, "xy south");
        route_case(1, 1, 1, 1, "xy local");
    endtask

    task automatic lookahead_test();
        route_case(0, 0, 1, 0, "lk one hop");
        route_case(0, 2, 1, 0, "lk turn north");
        route_case(2, 1, 3, 2, "lk turn south");
        route_case(3, 2, 0, 0, "lk long west");
        route_case(3, 0, 3, 2, "lk straight south");
    endtask

    task automatic addr_error_test();
        route_case(1, 1, 2, 3, "bad dest y");
        route_case(0, 3, 1, 1, "bad cur y");
    endtask

    task automatic stream_test();
        int pulses;
        int cx;
        int cy;
        int dx;
        int dy;
        noc_route_pkg::port_t p;
        pulses = 0;
        for (int i = 0; i < 202; i++) begin
            @(posedge clk);
            if (i < 200) begin
                cx = $urandom_range(NX - 1, 0);
                cy = $urandom_range(NY - 1, 0);
                dx = $urandom_range(NX - 1, 0);
                dy = $urandom_range(NY - 1, 0);
                p = xy_ref(cx, cy, dx, dy);
                exp_port_q.push_back(p);
                exp_lk_q.push_back(xy_ref(step_x(cx, p), step_y(cy, p), dx, dy));
                in_valid    <= 1'b1;
                cur_r_addr  <= pack_addr(cx, cy);
                dest_e_addr <= pack_addr(dx, dy);
            end else begin
                in_valid <= 1'b0;
            end
            @(negedge clk);
            check_flag(out_valid, (i >= 1 && i <= 200), "stream out_valid");
            if (out_valid === 1'b1) begin
                pulses++;
                if (exp_port_q.size() == 0) begin
                    $display("Error at %0t: out_valid pulse with no request pending", $time);
                    mismatch_count++;
                end else begin
                    check_port(out_destport, exp_port_q.pop_front(), "stream out_destport");
                    check_port(out_lkdestport, exp_lk_q.pop_front(), "stream out_lkdestport");
                    check_flag(out_addr_err, 1'b0, "stream out_addr_err");
                end
            end
        end
        if (pulses != 200) begin
            $display("Error: stream gave %0d out_valid pulses for 200 requests", pulses);
            mismatch_count++;
        end
    endtask

    initial begin
        mismatch_count = 0;
        timeout_count  = 0;
        void'($urandom(98)); // seeds the generator once
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        cur_r_addr  = '0;
        dest_e_addr = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        reset_state_test();
        directed_xy_test();
        lookahead_test();
        addr_error_test();
        stream_test();
        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
noc_route_pkg.sv
mesh_addr_decode.sv
xy_port_select.sv
next_router_step.sv
lookahead_route_ctrl.sv
mesh_lookahead_route.sv
tb_mesh_route.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the mesh look-ahead routing testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
    --top-module tb_mesh_route \
    -f verilog.f \
    -o sim_tb

./obj_dir/sim_tb > "$LOG" 2>&1
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
